//--- logic/mctp_pkg.sv
package mctp_pkg;

        // ==========================================================
        // Field types
        // ==========================================================
        typedef logic [1:0] seq_t;      // Packet sequence wraps mod 4
        typedef logic [2:0] tag_t;
        typedef logic [7:0] eid_t;
        typedef logic [7:0] len_dw_t;   // Length in doublewords
        typedef logic [3:0] hdr_ver_t;
        typedef logic [7:0] err_cnt_t;
        typedef logic [2:0] frag_cnt_t; // Fragment count saturates at 7

        // Encoded as {SOM, EOM}
        typedef enum logic [1:0] {
                FRAG_MIDDLE = 2'b00,
                FRAG_LAST   = 2'b01,
                FRAG_FIRST  = 2'b10,
                FRAG_SINGLE = 2'b11
        } frag_kind_t;

        localparam int       NUM_TAGS    = 8;
        localparam hdr_ver_t HDR_VERSION = 4'd1;
        localparam len_dw_t  MIN_UNIT_DW = 8'd16;  // 64 bytes
        localparam eid_t     BCAST_EID   = 8'hFF;
        localparam eid_t     NULL_EID    = 8'h00;
        localparam tag_t     OWNER_TAG   = 3'd7;   // Needs tag owner set

        // Header error bit index is the check priority
        localparam int NUM_HDR_ERR = 4;
        localparam int HERR_VER    = 0;
        localparam int HERR_DST    = 1;
        localparam int HERR_TO     = 2;
        localparam int HERR_SIZE   = 3;

        typedef logic [NUM_HDR_ERR-1:0] hdr_err_t;

        // ==========================================================
        // Shared structs
        // ==========================================================
        typedef struct packed {
                logic        som;           // [127]
                logic        eom;           // [126]
                seq_t        seq;           // [125:124]
                logic        tag_owner;     // [123]
                tag_t        tag;           // [122:120]
                eid_t        src_eid;       // [119:112]
                eid_t        dst_eid;       // [111:104]
                logic [3:0]  rsvd_hv;
                hdr_ver_t    hdr_ver;       // [99:96]
                logic [15:0] vendor_id;     // [95:80]
                logic [15:0] target_id;
                logic [7:0]  msg_code;      // [63:56]
                logic [7:0]  pad_vdm_code;  // Padding and VDM code
                logic [15:0] requester_id;
                len_dw_t     length;        // [31:24]
                logic [15:0] attr;
                logic [7:0]  fmt_type;      // [7:0]
        } mctp_hdr_t;

        typedef struct packed {
                logic       valid;
                frag_kind_t kind;
                seq_t       seq;
                logic       tag_owner;
                tag_t       tag;
                eid_t       src_eid;
                len_dw_t    length;
        } frag_t;

        typedef struct packed {
                logic      restart;
                logic      mid_no_first;
                logic      out_of_seq;
                logic      size_mismatch;
                logic      done;
                frag_cnt_t frags;       // Valid with done
        } ctx_evt_t;

        typedef struct packed {
                err_cnt_t bad_ver;
                err_cnt_t unk_dst;
                err_cnt_t tag_owner;
                err_cnt_t mid_no_first;
                err_cnt_t unit_size;
                err_cnt_t size_mismatch;
                err_cnt_t restart;
                err_cnt_t out_of_seq;
        } err_counts_t;

endpackage

//--- logic/mctp_hdr_decode.sv
`timescale 1ns/1ps

module mctp_hdr_decode (
        input  logic                i_clk,
        input  logic                i_rst_n,
        input  logic                i_frag_valid,
        input  mctp_pkg::mctp_hdr_t i_hdr,
        input  mctp_pkg::eid_t      i_own_eid,
        input  logic                i_dst_chk_en,
        output mctp_pkg::frag_t     o_frag,
        output mctp_pkg::hdr_err_t  o_hdr_err
);
        import mctp_pkg::*;

        frag_kind_t kind;
        logic       ver_bad;
        logic       dst_bad;
        logic       to_bad;
        logic       size_bad;
        hdr_err_t   err_nxt;

        assign kind    = frag_kind_t'({i_hdr.som, i_hdr.eom});
        assign ver_bad = (i_hdr.hdr_ver != HDR_VERSION);

        // Null and broadcast are always accepted
        assign dst_bad = i_dst_chk_en &&
                         (i_hdr.dst_eid != NULL_EID) &&
                         (i_hdr.dst_eid != BCAST_EID) &&
                         (i_hdr.dst_eid != i_own_eid);

        assign to_bad   = (i_hdr.tag == OWNER_TAG) && !i_hdr.tag_owner;
        assign size_bad = (kind inside {FRAG_FIRST, FRAG_SINGLE}) &&
                          (i_hdr.length < MIN_UNIT_DW);  // Unit size set by first fragment

        // First failing check wins
        always_comb begin
                err_nxt = '0;
                if (i_frag_valid) begin
                        if (ver_bad)
                                err_nxt[HERR_VER] = 1'b1;
                        else if (dst_bad)
                                err_nxt[HERR_DST] = 1'b1;
                        else if (to_bad)
                                err_nxt[HERR_TO] = 1'b1;
                        else if (size_bad)
                                err_nxt[HERR_SIZE] = 1'b1;
                end
        end

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_frag    <= '0;
                        o_hdr_err <= '0;
                end else begin
                        o_frag.valid     <= i_frag_valid && (err_nxt == '0);
                        o_frag.kind      <= kind;
                        o_frag.seq       <= i_hdr.seq;
                        o_frag.tag_owner <= i_hdr.tag_owner;
                        o_frag.tag       <= i_hdr.tag;
                        o_frag.src_eid   <= i_hdr.src_eid;
                        o_frag.length    <= i_hdr.length;
                        o_hdr_err        <= err_nxt;
                end
        end

        // At most one error class per header
        a_hdr_err_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                $onehot0(o_hdr_err));

endmodule

//--- logic/mctp_assembly_ctx.sv
`timescale 1ns/1ps

module mctp_assembly_ctx #(
        parameter mctp_pkg::tag_t CTX_TAG = '0
) (
        input  logic               i_clk,
        input  logic               i_rst_n,
        input  mctp_pkg::frag_t    i_frag,
        output mctp_pkg::ctx_evt_t o_evt
);
        import mctp_pkg::*;

        typedef enum logic {
                CTX_IDLE,
                CTX_ASSEMBLE
        } ctx_state_t;

        ctx_state_t state_q;
        ctx_state_t state_nxt;
        eid_t       src_q;
        eid_t       src_nxt;
        logic       to_q;
        logic       to_nxt;
        len_dw_t    len_q;
        len_dw_t    len_nxt;
        seq_t       exp_seq_q;
        seq_t       exp_seq_nxt;
        frag_cnt_t  cnt_q;
        frag_cnt_t  cnt_nxt;
        ctx_evt_t   evt_nxt;
        logic       hit;
        logic       same_owner;
        logic       size_bad;

        assign hit = i_frag.valid && (i_frag.tag == CTX_TAG);

        // Active message from the same source and tag owner
        assign same_owner = (state_q == CTX_ASSEMBLE) &&
                            (src_q == i_frag.src_eid) &&
                            (to_q == i_frag.tag_owner);

        // Middles repeat the unit length and a last may be shorter
        assign size_bad = ((i_frag.kind == FRAG_MIDDLE) && (i_frag.length != len_q)) ||
                          ((i_frag.kind == FRAG_LAST) && (i_frag.length > len_q));

        // ==========================================================
        // Context rules
        // ==========================================================
        always_comb begin
                evt_nxt     = '0;
                state_nxt   = state_q;
                src_nxt     = src_q;
                to_nxt      = to_q;
                len_nxt     = len_q;
                exp_seq_nxt = exp_seq_q;
                cnt_nxt     = cnt_q;
                if (hit) begin
                        if (i_frag.kind inside {FRAG_FIRST, FRAG_SINGLE}) begin
                                evt_nxt.restart = same_owner;
                                src_nxt         = i_frag.src_eid;
                                to_nxt          = i_frag.tag_owner;
                                len_nxt         = i_frag.length;
                                exp_seq_nxt     = i_frag.seq + 2'd1;
                                cnt_nxt         = 3'd1;
                                if (i_frag.kind == FRAG_SINGLE) begin
                                        state_nxt     = CTX_IDLE;  // Complete on its own
                                        evt_nxt.done  = 1'b1;
                                        evt_nxt.frags = 3'd1;
                                end else begin
                                        state_nxt = CTX_ASSEMBLE;
                                end
                        end else if (!same_owner) begin
                                evt_nxt.mid_no_first = 1'b1;  // State left as is
                        end else if (i_frag.seq != exp_seq_q) begin
                                evt_nxt.out_of_seq = 1'b1;
                                state_nxt          = CTX_IDLE;
                        end else if (size_bad) begin
                                evt_nxt.size_mismatch = 1'b1;
                                state_nxt             = CTX_IDLE;
                        end else begin
                                exp_seq_nxt = exp_seq_q + 2'd1;
                                cnt_nxt     = (cnt_q == '1) ? cnt_q : cnt_q + 3'd1;
                                if (i_frag.kind == FRAG_LAST) begin
                                        state_nxt     = CTX_IDLE;
                                        evt_nxt.done  = 1'b1;
                                        evt_nxt.frags = cnt_nxt;
                                end
                        end
                end
        end

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        state_q <= CTX_IDLE;
                        o_evt   <= '0;
                end else begin
                        state_q <= state_nxt;
                        o_evt   <= evt_nxt;
                end
        end

        // Stored fields of the open message
        always_ff @(posedge i_clk) begin
                src_q     <= src_nxt;
                to_q      <= to_nxt;
                len_q     <= len_nxt;
                exp_seq_q <= exp_seq_nxt;
                cnt_q     <= cnt_nxt;
        end

        // At most one error flag per fragment
        a_one_err: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                $onehot0({o_evt.restart, o_evt.mid_no_first, o_evt.out_of_seq,
                          o_evt.size_mismatch}));

endmodule

//--- logic/mctp_err_counters.sv
`timescale 1ns/1ps

module mctp_err_counters (
        input  logic                                        i_clk,
        input  logic                                        i_rst_n,
        input  mctp_pkg::hdr_err_t                          i_hdr_err,
        input  mctp_pkg::ctx_evt_t [mctp_pkg::NUM_TAGS-1:0] i_evt,
        output mctp_pkg::err_counts_t                       o_counts,
        output logic                                        o_msg_done,
        output mctp_pkg::tag_t                              o_msg_tag,
        output logic [7:0]                                  o_msg_frags
);
        import mctp_pkg::*;

        hdr_err_t            hdr_err_q;  // Lines header errors up with context events
        ctx_evt_t            evt_any;
        tag_t                done_tag;
        logic [NUM_TAGS-1:0] reporting;

        function automatic err_cnt_t sat_inc(input err_cnt_t cnt, input logic inc);
                if (inc && (cnt != '1))
                        return cnt + 8'd1;
                return cnt;
        endfunction

        // Only the addressed context can report in a cycle
        always_comb begin
                evt_any  = '0;
                done_tag = '0;
                for (int t = 0; t < NUM_TAGS; t++) begin
                        reporting[t] = (i_evt[t] != '0);
                        evt_any      = evt_any | i_evt[t];
                        if (i_evt[t].done)
                                done_tag = tag_t'(t);
                end
        end

        // ==========================================================
        // Saturating counters
        // ==========================================================
        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        hdr_err_q  <= '0;
                        o_counts   <= '0;
                        o_msg_done <= 1'b0;
                end else begin
                        hdr_err_q              <= i_hdr_err;
                        o_counts.bad_ver       <= sat_inc(o_counts.bad_ver, hdr_err_q[HERR_VER]);
                        o_counts.unk_dst       <= sat_inc(o_counts.unk_dst, hdr_err_q[HERR_DST]);
                        o_counts.tag_owner     <= sat_inc(o_counts.tag_owner, hdr_err_q[HERR_TO]);
                        o_counts.unit_size     <= sat_inc(o_counts.unit_size, hdr_err_q[HERR_SIZE]);
                        o_counts.mid_no_first  <= sat_inc(o_counts.mid_no_first,
                                                          evt_any.mid_no_first);
                        o_counts.size_mismatch <= sat_inc(o_counts.size_mismatch,
                                                          evt_any.size_mismatch);
                        o_counts.restart       <= sat_inc(o_counts.restart, evt_any.restart);
                        o_counts.out_of_seq    <= sat_inc(o_counts.out_of_seq, evt_any.out_of_seq);
                        o_msg_done             <= evt_any.done;
                end
        end

        always_ff @(posedge i_clk) begin
                if (evt_any.done) begin
                        o_msg_tag   <= done_tag;
                        o_msg_frags <= 8'(evt_any.frags);
                end
        end

        a_one_ctx: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                $onehot0(reporting));

endmodule

//--- logic/mctp_rx_checker.sv
`timescale 1ns/1ps

module mctp_rx_checker (
        input  logic                  i_clk,
        input  logic                  i_rst_n,
        input  logic                  i_frag_valid,
        input  mctp_pkg::mctp_hdr_t   i_hdr,
        input  mctp_pkg::eid_t        i_own_eid,
        input  logic                  i_dst_chk_en,
        output mctp_pkg::err_counts_t o_counts,
        output logic                  o_msg_done,
        output mctp_pkg::tag_t        o_msg_tag,
        output logic [7:0]            o_msg_frags
);
        import mctp_pkg::*;

        frag_t                   frag;     // Broadcast to every context
        hdr_err_t                hdr_err;
        ctx_evt_t [NUM_TAGS-1:0] ctx_evt;

        // ==========================================================
        // Header checks
        // ==========================================================
        mctp_hdr_decode mctp_hdr_decode_i (
                .i_clk        (i_clk),
                .i_rst_n      (i_rst_n),
                .i_frag_valid (i_frag_valid),
                .i_hdr        (i_hdr),
                .i_own_eid    (i_own_eid),
                .i_dst_chk_en (i_dst_chk_en),
                .o_frag       (frag),
                .o_hdr_err    (hdr_err)
        );

        // One reassembly context per message tag
        for (genvar g = 0; g < NUM_TAGS; g++) begin : g_ctx
                mctp_assembly_ctx #(
                        .CTX_TAG (tag_t'(g))
                ) mctp_assembly_ctx_i (
                        .i_clk   (i_clk),
                        .i_rst_n (i_rst_n),
                        .i_frag  (frag),
                        .o_evt   (ctx_evt[g])
                );
        end

        mctp_err_counters mctp_err_counters_i (
                .i_clk       (i_clk),
                .i_rst_n     (i_rst_n),
                .i_hdr_err   (hdr_err),
                .i_evt       (ctx_evt),
                .o_counts    (o_counts),
                .o_msg_done  (o_msg_done),
                .o_msg_tag   (o_msg_tag),
                .o_msg_frags (o_msg_frags)
        );

endmodule

//--- verification/mctp_rx_model.svh
`ifndef MCTP_RX_MODEL_SVH
`define MCTP_RX_MODEL_SVH

// Expected outputs for one cycle
typedef struct packed {
        logic        done;
        tag_t        tag;
        logic [7:0]  frags;
        err_counts_t counts;
} exp_t;

// Per tag reassembly state
logic        m_active [NUM_TAGS] = '{default: 1'b0};
eid_t        m_src    [NUM_TAGS] = '{default: 8'h00};
logic        m_to     [NUM_TAGS] = '{default: 1'b0};
len_dw_t     m_len    [NUM_TAGS] = '{default: 8'h00};
seq_t        m_seq    [NUM_TAGS] = '{default: 2'd0};
frag_cnt_t   m_cnt    [NUM_TAGS] = '{default: 3'd0};
err_counts_t m_counts            = '0;

function automatic err_cnt_t bump_sat(input err_cnt_t c);
        return (c == 8'hff) ? c : c + 8'd1;
endfunction

// Applies one strobe in arrival order
task automatic model_step(input logic valid, input mctp_hdr_t h, input eid_t own,
                          input logic chk_en, output exp_t e);
        tag_t t;
        logic same;
        t    = h.tag;
        same = m_active[t] && (m_src[t] == h.src_eid) && (m_to[t] == h.tag_owner);
        e    = '0;
        if (valid) begin
                // Only the first failing header check counts
                if (h.hdr_ver != HDR_VERSION)
                        m_counts.bad_ver = bump_sat(m_counts.bad_ver);
                else if (chk_en && h.dst_eid != NULL_EID && h.dst_eid != BCAST_EID &&
                         h.dst_eid != own)
                        m_counts.unk_dst = bump_sat(m_counts.unk_dst);
                else if (h.tag == OWNER_TAG && !h.tag_owner)
                        m_counts.tag_owner = bump_sat(m_counts.tag_owner);
                else if (h.som && h.length < MIN_UNIT_DW)
                        m_counts.unit_size = bump_sat(m_counts.unit_size);
                else if (h.som) begin
                        if (same)
                                m_counts.restart = bump_sat(m_counts.restart);
                        m_src[t]    = h.src_eid;
                        m_to[t]     = h.tag_owner;
                        m_len[t]    = h.length;
                        m_seq[t]    = h.seq + 2'd1;
                        m_cnt[t]    = 3'd1;
                        m_active[t] = !h.eom;
                        e.done      = h.eom;      // Single fragment
                        e.frags     = 8'd1;
                end else if (!same)
                        m_counts.mid_no_first = bump_sat(m_counts.mid_no_first);
                else if (h.seq != m_seq[t]) begin
                        m_counts.out_of_seq = bump_sat(m_counts.out_of_seq);
                        m_active[t]         = 1'b0;
                end else if (h.eom ? (h.length > m_len[t]) : (h.length != m_len[t])) begin
                        m_counts.size_mismatch = bump_sat(m_counts.size_mismatch);
                        m_active[t]            = 1'b0;
                end else begin
                        m_seq[t] = m_seq[t] + 2'd1;
                        if (m_cnt[t] != 3'd7)
                                m_cnt[t] = m_cnt[t] + 3'd1;
                        if (h.eom) begin
                                m_active[t] = 1'b0;
                                e.done      = 1'b1;
                                e.frags     = {5'd0, m_cnt[t]};
                        end
                end
        end
        e.tag    = t;
        e.counts = m_counts;
endtask

`endif

//--- verification/mctp_rx_checker_tb.sv
`timescale 1ns/1ps

module mctp_rx_checker_tb;
        import mctp_pkg::*;

        localparam int   RST_CYCLES  = 16;
        localparam int   N_RAND      = 400;    // Per config phase
        localparam int   N_SAT       = 300;
        localparam int   WATCHDOG_NS = (RST_CYCLES + (2 * N_RAND + N_SAT + 4) * 3) * 20;
        localparam eid_t OWN_EID     = 8'h1d;

        logic        i_clk;
        logic        i_rst_n;
        logic        i_frag_valid;
        mctp_hdr_t   i_hdr;
        eid_t        i_own_eid;
        logic        i_dst_chk_en;
        err_counts_t o_counts;
        logic        o_msg_done;
        tag_t        o_msg_tag;
        logic [7:0]  o_msg_frags;

        logic [31:0] rng_state = 32'h5a1d_79a8;
        int          n_done    = 0;

`include "mctp_rx_model.svh"

        exp_t exp_q[$];  // One entry per driven cycle

        mctp_rx_checker mctp_rx_checker_i (
                .i_clk        (i_clk),
                .i_rst_n      (i_rst_n),
                .i_frag_valid (i_frag_valid),
                .i_hdr        (i_hdr),
                .i_own_eid    (i_own_eid),
                .i_dst_chk_en (i_dst_chk_en),
                .o_counts     (o_counts),
                .o_msg_done   (o_msg_done),
                .o_msg_tag    (o_msg_tag),
                .o_msg_frags  (o_msg_frags)
        );

        initial begin
                i_clk = 1'b0;
                forever #10 i_clk = ~i_clk;
        end

        function automatic logic [31:0] next_rand();
                rng_state = rng_state * 32'd1664525 + 32'd1013904223;
                return rng_state;
        endfunction

        task automatic compare_value(input string name, input logic [63:0] got,
                                     input logic [63:0] want);
                if (got !== want) begin
                        $display("error at %0t ns: %s is %0h, expected %0h",
                                 $time, name, got, want);
                        $display("test failed");
                        $fatal(1, "output mismatch");
                end
        endtask

        // ==========================================================
        // Stimulus
        // ==========================================================
        // Mostly well formed fragments steered by the model's view of each tag
        task automatic make_frag(output logic valid, output mctp_hdr_t h);
                logic [31:0] r;
                logic [31:0] q;
                tag_t        t;
                frag_kind_t  kind;
                r = next_rand();
                q = next_rand();
                t = r[2:0];
                h = '0;
                h.fmt_type  = 8'h72;
                h.msg_code  = 8'h7f;   // Vendor defined type 1
                h.vendor_id = 16'h1ab4;
                h.tag       = t;
                h.tag_owner = (r[5:3] != 3'd0);
                h.hdr_ver   = (r[9:6] != 4'd0) ? HDR_VERSION : r[23:20];
                case (r[12:10])
                        3'd0:    h.dst_eid = r[19:12];
                        3'd1:    h.dst_eid = NULL_EID;
                        3'd2:    h.dst_eid = BCAST_EID;
                        default: h.dst_eid = OWN_EID;
                endcase
                h.src_eid = (m_active[t] && q[20:18] != 3'd0) ? m_src[t] : 8'h10 + {6'd0, q[22:21]};
                if (m_active[t])
                        kind = (q[2:0] == 3'd0) ? FRAG_FIRST : (q[2] ? FRAG_LAST : FRAG_MIDDLE);
                else
                        kind = !q[2] ? FRAG_FIRST :
                               (q[1] ? (q[0] ? FRAG_LAST : FRAG_MIDDLE) : FRAG_SINGLE);
                {h.som, h.eom} = kind;
                h.seq = (!h.som && q[6:3] != 4'd0) ? m_seq[t] : q[8:7];
                if (h.som)
                        h.length = (q[11:9] == 3'd0) ? {4'h0, q[15:12]} : (q[16] ? 8'd16 : 8'd32);
                else if (q[11:9] == 3'd0)
                        h.length = q[16] ? 8'd16 : 8'd32;
                else if (q[11:9] == 3'd1 && h.eom)
                        h.length = m_len[t] - 8'd4;   // Short last fragment
                else
                        h.length = m_len[t];
                valid = (r[31:29] != 3'd0);
        endtask

        task automatic run_phase(input int n, input logic chk_en, input logic bad_ver,
                                 input logic idle);
                logic      valid;
                mctp_hdr_t h;
                exp_t      e;
                for (int i = 0; i < n; i++) begin
                        @(posedge i_clk);
                        make_frag(valid, h);
                        if (bad_ver) begin
                                valid     = 1'b1;
                                h.hdr_ver = 4'd0;
                        end
                        if (idle)
                                valid = 1'b0;
                        i_frag_valid <= valid;
                        i_hdr        <= h;
                        i_dst_chk_en <= chk_en;
                        model_step(valid, h, OWN_EID, chk_en, e);
                        exp_q.push_back(e);
                end
        endtask

        // ==========================================================
        // Checking
        // ==========================================================
        // Outputs lag the drive edge by three clocks
        always @(negedge i_clk) begin : check_outputs
                exp_t e;
                if (exp_q.size() == 4) begin
                        e = exp_q.pop_front();
                        compare_value("o_msg_done", 64'(o_msg_done), 64'(e.done));
                        if (e.done) begin
                                n_done++;
                                compare_value("o_msg_tag", 64'(o_msg_tag), 64'(e.tag));
                                compare_value("o_msg_frags", 64'(o_msg_frags), 64'(e.frags));
                        end
                        compare_value("o_counts", 64'(o_counts), 64'(e.counts));
                end
        end

        initial begin
                #(WATCHDOG_NS);
                $display("timeout: the run did not finish in the expected time");
                $display("test failed");
                $fatal(1, "watchdog expired");
        end

        initial begin
                i_rst_n      = 1'b0;
                i_frag_valid = 1'b0;
                i_hdr        = '0;
                i_own_eid    = OWN_EID;
                i_dst_chk_en = 1'b0;
                repeat (RST_CYCLES) @(posedge i_clk);
                i_rst_n <= 1'b1;
                run_phase(N_RAND, 1'b1, 1'b0, 1'b0);
                run_phase(N_RAND, 1'b0, 1'b0, 1'b0);
                run_phase(N_SAT, 1'b0, 1'b1, 1'b0);   // Drives bad_ver to saturation
                run_phase(4, 1'b0, 1'b0, 1'b1);       // Drain the pipeline
                @(negedge i_clk);
                if (n_done > 0 && o_counts.bad_ver == 8'hff) begin
                        $display("test passed");
                        $finish;
                end else begin
                        $display("no message completed or bad version count not saturated");
                        $display("test failed");
                        $fatal(1, "incomplete run");
                end
        end

endmodule

//--- compile.f
+incdir+verification
logic/mctp_pkg.sv
logic/mctp_hdr_decode.sv
logic/mctp_assembly_ctx.sv
logic/mctp_err_counters.sv
logic/mctp_rx_checker.sv
verification/mctp_rx_checker_tb.sv

//--- Makefile
TOP := mctp_rx_checker_tb

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "test passed" sim.log

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
